// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing -j 0
TOP      := tb_alu_engine
FILELIST := verilog.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Result: PASS"; \
	else \
	  echo "Result: FAIL"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: src/alu_egress_stage.sv
`timescale 1ns/1ps
`include "engine_params.svh"

module alu_egress_stage
  import engine_pkg::*;
(
  input  logic           ap_clk,
  input  logic           areset,
  input  logic           res_valid,
  input  memory_packet_t res_packet,
  input  logic           out_credit,
  output logic           out_valid,
  output memory_packet_t out_packet,
  output logic           slot_free
);

  localparam int DEPTH = `ENGINE_OUT_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int CRD_W = $clog2(`ENGINE_OUT_CREDITS + 1);

  memory_packet_t   fifo_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fill;
  logic [CRD_W-1:0] out_credits;
  logic             push;
  logic             send;

  // Room is reserved by the internal credits, so a result is never dropped
  assign push = res_valid && (fill != CNT_W'(DEPTH));
  assign send = (fill != '0) && (out_credits != '0);

  always_ff @(posedge ap_clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= res_packet;
    end
  end

  always_ff @(posedge ap_clk or posedge areset) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (send) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, send})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

  // Output credits, a send and a returned credit together leave it unchanged
  always_ff @(posedge ap_clk or posedge areset) begin
    if (areset) begin
      out_credits <= CRD_W'(`ENGINE_OUT_CREDITS);
    end else begin
      case ({send, out_credit})
        2'b10:   out_credits <= out_credits - 1'b1;
        2'b01:   out_credits <= out_credits + 1'b1;
        default: out_credits <= out_credits;
      endcase
    end
  end

  always_ff @(posedge ap_clk or posedge areset) begin
    if (areset) begin
      out_valid <= 1'b0;
      slot_free <= 1'b0;
    end else begin
      out_valid <= send;
      // Each send frees one slot back to the ingress
      slot_free <= send;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (send) begin
      out_packet <= fifo_mem[rd_ptr];
    end
  end

endmodule

// File: src/alu_engine_top.sv
`timescale 1ns/1ps
`include "engine_params.svh"

module alu_engine_top
  import engine_pkg::*;
(
  input  logic           ap_clk,
  input  logic           areset,
  input  logic           clear,
  input  logic           in_valid,
  input  memory_packet_t in_packet,
  input  logic           cfg_valid,
  input  alu_config_t    cfg,
  output logic           in_credit,
  output logic           out_valid,
  output memory_packet_t out_packet,
  input  logic           out_credit
);

  logic           issue_valid;
  alu_item_t      issue_item;
  logic           res_valid;
  memory_packet_t res_packet;
  // Internal credit return from egress to ingress
  logic           slot_free;

  alu_ingress_stage i_ingress (
    .ap_clk      (ap_clk),
    .areset      (areset),
    .in_valid    (in_valid),
    .in_packet   (in_packet),
    .cfg_valid   (cfg_valid),
    .cfg         (cfg),
    .slot_free   (slot_free),
    .in_credit   (in_credit),
    .issue_valid (issue_valid),
    .issue_item  (issue_item)
  );

  alu_ops_kernel i_kernel (
    .ap_clk      (ap_clk),
    .areset      (areset),
    .clear       (clear),
    .issue_valid (issue_valid),
    .issue_item  (issue_item),
    .res_valid   (res_valid),
    .res_packet  (res_packet)
  );

  alu_egress_stage i_egress (
    .ap_clk     (ap_clk),
    .areset     (areset),
    .res_valid  (res_valid),
    .res_packet (res_packet),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_packet (out_packet),
    .slot_free  (slot_free)
  );

endmodule

// File: src/alu_ingress_stage.sv
`timescale 1ns/1ps
`include "engine_params.svh"

module alu_ingress_stage
  import engine_pkg::*;
(
  input  logic           ap_clk,
  input  logic           areset,
  input  logic           in_valid,
  input  memory_packet_t in_packet,
  input  logic           cfg_valid,
  input  alu_config_t    cfg,
  input  logic           slot_free,
  output logic           in_credit,
  output logic           issue_valid,
  output alu_item_t      issue_item
);

  localparam int DEPTH = `ENGINE_IN_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int CRD_W = $clog2(`ENGINE_OUT_DEPTH + 1);

  memory_packet_t   fifo_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fill;
  logic [CRD_W-1:0] int_credits;
  alu_config_t      cfg_q;
  logic             push;
  logic             pop;

  // The producer only sends with a credit, the full check is a safety net
  assign push = in_valid && (fill != CNT_W'(DEPTH));
  // Pop only while the egress has a free slot reserved for the result
  assign pop  = (fill != '0) && (int_credits != '0);

  always_ff @(posedge ap_clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= in_packet;
    end
  end

  always_ff @(posedge ap_clk or posedge areset) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

  // Configuration register, a load takes effect for pops after this cycle
  always_ff @(posedge ap_clk or posedge areset) begin
    if (areset) begin
      cfg_q <= '0;
    end else if (cfg_valid) begin
      cfg_q <= cfg;
    end
  end

  // Internal credits, one per free egress FIFO slot
  always_ff @(posedge ap_clk or posedge areset) begin
    if (areset) begin
      int_credits <= CRD_W'(`ENGINE_OUT_DEPTH);
    end else begin
      case ({pop, slot_free})
        2'b10:   int_credits <= int_credits - 1'b1;
        2'b01:   int_credits <= int_credits + 1'b1;
        default: int_credits <= int_credits;
      endcase
    end
  end

  // Issue handshake and input credit return
  always_ff @(posedge ap_clk or posedge areset) begin
    if (areset) begin
      issue_valid <= 1'b0;
      in_credit   <= 1'b0;
    end else begin
      issue_valid <= pop;
      in_credit   <= pop;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (pop) begin
      issue_item.packet <= fifo_mem[rd_ptr];
      issue_item.cfg    <= cfg_q;
    end
  end

endmodule

// File: src/alu_ops_kernel.sv
`timescale 1ns/1ps
`include "engine_params.svh"

module alu_ops_kernel
  import engine_pkg::*;
(
  input  logic           ap_clk,
  input  logic           areset,
  input  logic           clear,
  input  logic           issue_valid,
  input  alu_item_t      issue_item,
  output logic           res_valid,
  output memory_packet_t res_packet
);

  localparam int FW = `ENGINE_FIELD_W;
  localparam int NF = `ENGINE_NUM_FIELDS;

  memory_packet_t  sel_operands;
  memory_packet_t  s1_operands;
  alu_op_e         s1_op;
  logic [NF-1:0]   s1_mask;
  logic            s1_valid;

  logic [2*FW-1:0] op0_wide;
  logic [2*FW-1:0] op1_wide;
  logic [2*FW-1:0] masked_sum;
  logic [2*FW-1:0] acc_q;
  logic [2*FW-1:0] acc_base;
  logic [2*FW-1:0] acc_next;
  logic [2*FW-1:0] alu_result;
  logic [2*FW-1:0] s2_result;
  logic            s2_valid;

  // Operand select, field 0 always stays the packet value
  always_comb begin
    sel_operands = issue_item.packet;
    for (int i = 1; i < NF; i++) begin
      if (issue_item.cfg.operate_on_constant && issue_item.cfg.alu_mask[i]) begin
        sel_operands[i] = issue_item.cfg.constant_value;
      end
    end
  end

  // Stage 1 registers
  always_ff @(posedge ap_clk or posedge areset) begin
    if (areset) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= issue_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (issue_valid) begin
      s1_operands <= sel_operands;
      s1_op       <= issue_item.cfg.alu_operation;
      s1_mask     <= issue_item.cfg.alu_mask;
    end
  end

  assign op0_wide = {{FW{1'b0}}, s1_operands[0]};
  assign op1_wide = {{FW{1'b0}}, s1_operands[1]};

  // Sum of the masked fields from 1 upward, shared by ADD, SUB and ACC
  always_comb begin
    masked_sum = '0;
    for (int i = 1; i < NF; i++) begin
      if (s1_mask[i]) begin
        masked_sum = masked_sum + {{FW{1'b0}}, s1_operands[i]};
      end
    end
  end

  // A clear in the same cycle as an ACC item zeroes the sum first
  assign acc_base = clear ? '0 : acc_q;
  assign acc_next = acc_base + op0_wide + masked_sum;

  always_comb begin
    case (s1_op)
      ALU_NOP: alu_result = op0_wide;
      ALU_ADD: alu_result = op0_wide + masked_sum;
      ALU_SUB: alu_result = op0_wide - masked_sum;
      ALU_MUL: alu_result = op0_wide * op1_wide;
      ALU_ACC: alu_result = acc_next;
      default: alu_result = '0;
    endcase
  end

  always_ff @(posedge ap_clk or posedge areset) begin
    if (areset) begin
      acc_q <= '0;
    end else if (s1_valid && (s1_op == ALU_ACC)) begin
      acc_q <= acc_next;
    end else if (clear) begin
      acc_q <= '0;
    end
  end

  // Stage 2 registers
  always_ff @(posedge ap_clk or posedge areset) begin
    if (areset) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (s1_valid) begin
      s2_result <= alu_result;
    end
  end

  assign res_valid = s2_valid;

  // Low half to field 0, high half to field 1, the rest zero
  always_comb begin
    res_packet    = '0;
    res_packet[0] = s2_result[FW-1:0];
    res_packet[1] = s2_result[2*FW-1:FW];
  end

endmodule

// File: src/engine_params.svh
`ifndef ENGINE_PARAMS_SVH
`define ENGINE_PARAMS_SVH

// Width of one memory packet field
`define ENGINE_FIELD_W 32

// Fields carried by every memory packet
`define ENGINE_NUM_FIELDS 4

// Ingress FIFO depth, equal to the input credits granted at reset
`define ENGINE_IN_DEPTH 4

// Egress FIFO depth, equal to the internal ingress-to-egress credits
`define ENGINE_OUT_DEPTH 4

// Credits the downstream consumer grants at reset
`define ENGINE_OUT_CREDITS 2

`endif

// File: src/engine_pkg.sv
`include "engine_params.svh"

package engine_pkg;

  // ALU opcodes, encodings 5 to 7 are undefined and give a zero result
  typedef enum logic [2:0] {
    ALU_NOP = 3'd0,
    ALU_ADD = 3'd1,
    ALU_SUB = 3'd2,
    ALU_MUL = 3'd3,
    ALU_ACC = 3'd4
  } alu_op_e;

  // One memory packet, field 0 in the low bits
  typedef logic [`ENGINE_NUM_FIELDS-1:0][`ENGINE_FIELD_W-1:0] memory_packet_t;

  // ALU configuration as loaded through cfg_valid
  typedef struct packed {
    alu_op_e                       alu_operation;
    logic [`ENGINE_NUM_FIELDS-1:0] alu_mask;
    logic                          operate_on_constant;
    logic [`ENGINE_FIELD_W-1:0]    constant_value;
  } alu_config_t;

  // Packet issued to the kernel together with the configuration of its pop
  typedef struct packed {
    memory_packet_t packet;
    alu_config_t    cfg;
  } alu_item_t;

endpackage

// File: verif/tb_alu_model.svh
`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

// Results are computed at twice the field width
localparam int MODEL_W = 2 * `ENGINE_FIELD_W;

int error_count = 0;
int check_count = 0;

function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

// Wide result of one packet under configuration c, acc is the running sum before it
function automatic logic [MODEL_W-1:0] model_result(input memory_packet_t pkt,
                                                    input alu_config_t c,
                                                    input logic [MODEL_W-1:0] acc);
  logic [`ENGINE_FIELD_W-1:0] opnd [`ENGINE_NUM_FIELDS];
  logic [MODEL_W-1:0]         base;
  logic [MODEL_W-1:0]         masked;
  for (int i = 0; i < `ENGINE_NUM_FIELDS; i++) begin
    opnd[i] = pkt[i];
    // Field 0 is the base and keeps its packet value
    if (i > 0 && c.operate_on_constant && c.alu_mask[i]) begin
      opnd[i] = c.constant_value;
    end
  end
  base   = MODEL_W'(opnd[0]);
  masked = '0;
  for (int i = 1; i < `ENGINE_NUM_FIELDS; i++) begin
    if (c.alu_mask[i]) begin
      masked = masked + MODEL_W'(opnd[i]);
    end
  end
  case (c.alu_operation)
    ALU_NOP: return base;
    ALU_ADD: return base + masked;
    ALU_SUB: return base - masked;
    ALU_MUL: return base * MODEL_W'(opnd[1]);
    ALU_ACC: return acc + base + masked;
    default: return '0;
  endcase
endfunction

// Low half in field 0, high half in field 1
function automatic memory_packet_t to_packet(input logic [MODEL_W-1:0] r);
  memory_packet_t p;
  p    = '0;
  p[0] = r[`ENGINE_FIELD_W-1:0];
  p[1] = r[MODEL_W-1:`ENGINE_FIELD_W];
  return p;
endfunction

task automatic compare_packet(input string name, input memory_packet_t got,
                              input memory_packet_t exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
  end
endtask

task automatic compare_count(input string name, input int got, input int exp);
  check_count++;
  if (got != exp) begin
    error_count++;
    $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
  end
endtask

`endif

// File: verif/tb_alu_engine.sv
`timescale 1ns/1ps
`include "engine_params.svh"

module tb_alu_engine
  import engine_pkg::*;
();

  localparam logic [31:0] SEED = 32'h40d2397b;
  localparam int NUM_PACKETS = 400;
  localparam int CYCLE_LIMIT = NUM_PACKETS * 12 + 200;
  localparam int KIND_ARITH = 0;
  localparam int KIND_CONST = 1;
  localparam int KIND_ACC   = 2;
  localparam int KIND_MIXED = 3;
  localparam int KIND_UNDEF = 4;

  logic           ap_clk = 1'b0;
  logic           areset;
  logic           clear;
  logic           in_valid;
  memory_packet_t in_packet;
  logic           cfg_valid;
  alu_config_t    cfg;
  logic           in_credit;
  logic           out_valid;
  memory_packet_t out_packet;
  logic           out_credit = 1'b0;

  `include "tb_alu_model.svh"

  // Producer side
  logic [31:0]        drv_rng = SEED;
  int                 prod_credits = `ENGINE_IN_DEPTH;
  int                 accepted = 0;
  int                 in_credit_count = 0;
  int                 hold_left = 0;
  logic               hold_credits = 1'b0;
  alu_config_t        model_cfg = '0;
  logic [MODEL_W-1:0] model_acc = '0;
  memory_packet_t     expected_q [$];

  // Consumer side, its stream is offset from the same seed
  logic [31:0]        snk_rng = SEED ^ 32'h5555_5555;
  int                 dut_credits = `ENGINE_OUT_CREDITS;
  int                 owed = 0;
  int                 out_seen = 0;
  int                 cycle_count = 0;

  alu_engine_top i_dut (
    .ap_clk     (ap_clk),
    .areset     (areset),
    .clear      (clear),
    .in_valid   (in_valid),
    .in_packet  (in_packet),
    .cfg_valid  (cfg_valid),
    .cfg        (cfg),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_packet (out_packet),
    .out_credit (out_credit)
  );

  always #2 ap_clk = ~ap_clk;

  function automatic logic [31:0] drv_rand();
    drv_rng = lcg_next(drv_rng);
    return {drv_rng[15:0], drv_rng[31:16]};
  endfunction

  function automatic logic [31:0] snk_rand();
    snk_rng = lcg_next(snk_rng);
    return {snk_rng[15:0], snk_rng[31:16]};
  endfunction

  // Small, near all-ones or fully random values
  function automatic logic [`ENGINE_FIELD_W-1:0] make_field();
    logic [31:0] r;
    r = drv_rand();
    case (r[1:0])
      2'd0:    return `ENGINE_FIELD_W'(r[31:28]);
      2'd1:    return ~`ENGINE_FIELD_W'(r[31:28]);
      default: return `ENGINE_FIELD_W'(drv_rand());
    endcase
  endfunction

  function automatic memory_packet_t make_packet();
    memory_packet_t p;
    for (int i = 0; i < `ENGINE_NUM_FIELDS; i++) begin
      p[i] = make_field();
    end
    return p;
  endfunction

  function automatic alu_config_t make_config(input int kind);
    alu_config_t c;
    logic [31:0] r;
    r = drv_rand();
    case (kind)
      KIND_ARITH: c.alu_operation = alu_op_e'(3'(r[7:4] % 4));
      KIND_CONST: c.alu_operation = alu_op_e'(3'(1 + r[7:4] % 3));
      KIND_ACC:   c.alu_operation = ALU_ACC;
      KIND_MIXED: c.alu_operation = alu_op_e'(3'(r[7:4] % 5));
      default:    c.alu_operation = alu_op_e'(3'(5 + r[7:4] % 3));
    endcase
    c.alu_mask            = r[`ENGINE_NUM_FIELDS-1:0];
    c.operate_on_constant = (kind == KIND_CONST) || r[8];
    c.constant_value      = make_field();
    return c;
  endfunction

  // One clock of the producer, pulses from the last cycle drop here
  task automatic tick();
    @(posedge ap_clk);
    if (in_credit) begin
      prod_credits++;
      in_credit_count++;
    end
    if (hold_left > 0) begin
      hold_left--;
      if (hold_left == 0) begin
        hold_credits <= 1'b0;
      end
    end
    in_valid  <= 1'b0;
    cfg_valid <= 1'b0;
    clear     <= 1'b0;
  endtask

  task automatic wait_idle();
    while (out_seen != accepted) begin
      tick();
    end
  endtask

  task automatic wait_popped();
    while (in_credit_count != accepted) begin
      tick();
    end
  endtask

  // Packets still in the kernel or egress keep the configuration of their pop
  task automatic load_config(input alu_config_t c);
    wait_popped();
    tick();
    cfg_valid <= 1'b1;
    cfg       <= c;
    model_cfg = c;
  endtask

  // Clear only with the pipeline empty
  task automatic pulse_clear();
    wait_idle();
    tick();
    clear <= 1'b1;
    model_acc = '0;
  endtask

  task automatic send_packet(input memory_packet_t pkt);
    logic [MODEL_W-1:0] wide;
    tick();
    while (prod_credits == 0) begin
      tick();
    end
    wide = model_result(pkt, model_cfg, model_acc);
    if (model_cfg.alu_operation == ALU_ACC) begin
      model_acc = wide;
    end
    expected_q.push_back(to_packet(wide));
    in_valid  <= 1'b1;
    in_packet <= pkt;
    prod_credits--;
    accepted++;
  endtask

  // A fresh configuration every one to eight packets
  task automatic run_block(input int n, input int kind);
    int left;
    left = 0;
    for (int i = 0; i < n; i++) begin
      if (left == 0) begin
        if (kind == KIND_ACC && (drv_rand() % 2) == 0) begin
          pulse_clear();
        end
        load_config(make_config(kind));
        if (kind == KIND_MIXED && (drv_rand() % 2) == 0) begin
          hold_credits <= 1'b1;
          hold_left = 40 + drv_rand() % 60;
        end
        left = 1 + drv_rand() % 8;
      end
      send_packet(make_packet());
      repeat (drv_rand() % 3) begin
        tick();
      end
      left--;
    end
  endtask

  task automatic print_summary();
    $display("Errors: %0d, checks: %0d, packets sent: %0d, packets received: %0d",
             error_count, check_count, accepted, out_seen);
  endtask

  // Consumer and scoreboard
  always @(posedge ap_clk) begin
    if (!areset) begin
      out_credit <= 1'b0;
      if (out_valid) begin
        if (dut_credits == 0) begin
          error_count++;
          $display("out_valid fired while the DUT held no output credit");
        end else begin
          dut_credits--;
        end
        owed++;
        if (expected_q.size() == 0) begin
          error_count++;
          $display("Output packet arrived with no packet expected");
        end else begin
          compare_packet("out_packet", out_packet, expected_q.pop_front());
        end
        out_seen <= out_seen + 1;
      end
      if (owed > 0 && !hold_credits && (snk_rand() % 8) != 0) begin
        out_credit <= 1'b1;
        owed--;
        dut_credits++;
      end
    end
  end

  always @(posedge ap_clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      error_count++;
      $display("Timeout after %0d cycles with %0d of %0d packets delivered",
               cycle_count, out_seen, accepted);
      print_summary();
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    areset    <= 1'b1;
    clear     <= 1'b0;
    in_valid  <= 1'b0;
    in_packet <= '0;
    cfg_valid <= 1'b0;
    cfg       <= '0;
    repeat (5) @(posedge ap_clk);
    areset <= 1'b0;
    run_block(160, KIND_ARITH);
    run_block(40, KIND_CONST);
    run_block(80, KIND_ACC);
    run_block(100, KIND_MIXED);
    run_block(20, KIND_UNDEF);
    wait_idle();
    repeat (5) tick();
    compare_count("in_credit pulses", in_credit_count, accepted);
    compare_count("packets received", out_seen, accepted);
    compare_count("queued packets", expected_q.size(), 0);
    print_summary();
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+src
+incdir+verif
src/engine_pkg.sv
src/alu_ingress_stage.sv
src/alu_ops_kernel.sv
src/alu_egress_stage.sv
src/alu_engine_top.sv
verif/tb_alu_engine.sv
